/* mbExeTop.f */
common/mbIsaPkg.sv
common/mbExePkg.sv
src/mbOpDecode.sv
bsft/mbBarrelShift.sv
src/mbLogicUnit.sv
src/mbWriteback.sv
src/mbExeTop.sv
verification/mbExe_props.sv
verification/mbExeTb.sv

/* Makefile */
# Verilator build and run of the execute slice testbench

VERILATOR  ?= verilator
TOP        := mbExeTb
FILELIST   := mbExeTop.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides, the binary's exit status is not trusted on its own
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/mbExeTb.sv */
// Directed testbench for the execute slice that checks each writeback record against an ISA model
`timescale 1ns/1ps
`default_nettype none

module mbExeTb;

   import mbIsaPkg::*;
   import mbExePkg::*;

   // Words issued over all tests without stall cycles
   localparam int NUM_VEC   = 97;
   // Covers reset, drain and up to three stall cycles per stalled word
   localparam int MARGIN_NS = 2000;

   logic               sys_clk;
   logic               sys_rst;
   logic               sys_ena;
   logic               instrValid;
   mbInstrU            instr;
   logic [DATA_W-1:0]  rfA;
   logic [DATA_W-1:0]  rfB;
   mbWbS               wb;

   integer             seed;
   int                 errCount;
   int                 checkCount;
   // Enabled edges since reset
   int                 acceptCount;
   logic               checkNow;
   logic               holdNow;
   logic               stallMode;
   string              testName;
   mbWbS               wbLast;
   // Expected records in issue order with the test that issued each
   mbWbS               expQ[$];
   string              nameQ[$];

   mbExeTop mbExeTop_i (
      .sys_clk    (sys_clk),
      .sys_rst    (sys_rst),
      .sys_ena    (sys_ena),
      .instrValid (instrValid),
      .instr      (instr),
      .rfA        (rfA),
      .rfB        (rfB),
      .wb         (wb)
   );

   bind mbExeTop mbExe_props mbExe_props_i (
      .sys_clk (sys_clk),
      .sys_rst (sys_rst),
      .sys_ena (sys_ena),
      .wb      (wb)
   );

   always #10 sys_clk = ~sys_clk;

   // ISA model with S in bit 10 for left and T in bit 9 for arithmetic
   // Immediates are the sign-extended 16-bit field
   function automatic mbWbS refWb(input logic v, input mbInstrU ins,
                                  input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
      mbWbS               w;
      logic               legal;
      logic               isImm;
      logic [DATA_W-1:0]  opB;
      logic [DATA_W-1:0]  res;
      logic [4:0]         sh;
      legal = 1'b1;
      res   = '0;
      isImm = ins.typeA.opcode inside {OPC_BSI, OPC_ORI, OPC_ANDI, OPC_XORI, OPC_ANDNI};
      opB   = isImm ? {{16{ins.typeB.imm[15]}}, ins.typeB.imm} : b;
      sh    = opB[4:0];
      case (ins.typeA.opcode)
         OPC_BS, OPC_BSI: begin
            case (ins.typeB.imm[10:9])
               2'b00:   res = a >> sh;
               // Ones shifted in from the left for a negative operand
               2'b01:   res = (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
               2'b10:   res = a << sh;
               default: legal = 1'b0;
            endcase
         end
         OPC_OR, OPC_ORI:     res = a | opB;
         OPC_AND, OPC_ANDI:   res = a & opB;
         OPC_XOR, OPC_XORI:   res = a ^ opB;
         OPC_ANDN, OPC_ANDNI: res = a & ~opB;
         default:             legal = 1'b0;
      endcase
      w.valid   = v & legal;
      w.illegal = v & ~legal;
      w.rd      = ins.typeA.rd;
      w.data    = w.valid ? res : '0;
      return w;
   endfunction

   // Type A word with fixed ra and rb since operands come in on rfA and rfB
   function automatic mbInstrU mkRegOp(input logic [5:0] opc, input logic [4:0] rd,
                                       input logic [1:0] kind);
      mbInstrU w;
      w              = '0;
      w.typeA.opcode = opc;
      w.typeA.rd     = rd;
      w.typeA.ra     = 5'd1;
      w.typeA.rb     = 5'd2;
      w.typeA.func   = {kind, 9'd0};
      return w;
   endfunction

   function automatic mbInstrU mkImmOp(input logic [5:0] opc, input logic [4:0] rd,
                                       input logic [15:0] imm);
      mbInstrU w;
      w              = '0;
      w.typeB.opcode = opc;
      w.typeB.rd     = rd;
      w.typeB.ra     = 5'd1;
      w.typeB.imm    = imm;
      return w;
   endfunction

   task automatic compareData(input string name, input logic [DATA_W-1:0] expData,
                              input logic [DATA_W-1:0] actData);
      checkCount++;
      if (actData !== expData) begin
         errCount++;
         $display("ERROR %s: expected data %h, actual data %h at %0t",
                  name, expData, actData, $time);
      end
   endtask

   task automatic compareWb(input string name, input mbWbS expWb, input mbWbS actWb);
      checkCount++;
      if (actWb.valid !== expWb.valid || actWb.illegal !== expWb.illegal ||
          actWb.rd !== expWb.rd) begin
         errCount++;
         $display("ERROR %s: expected valid %b illegal %b rd %0d, actual valid %b illegal %b rd %0d",
                  name, expWb.valid, expWb.illegal, expWb.rd,
                  actWb.valid, actWb.illegal, actWb.rd);
      end
      compareData(name, expWb.data, actWb.data);
   endtask

   // Present one word and optionally stall before the enabled edge that accepts it
   task automatic issue(input logic v, input mbInstrU ins,
                        input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
      int gap;
      instrValid = v;
      instr      = ins;
      rfA        = a;
      rfB        = b;
      expQ.push_back(refWb(v, ins, a, b));
      nameQ.push_back(testName);
      gap = stallMode ? int'($unsigned($random(seed)) % 4) : 0;
      repeat (gap) begin
         sys_ena = 1'b0;
         @(posedge sys_clk);
         #1;
      end
      sys_ena = 1'b1;
      @(posedge sys_clk);
      #1;
   endtask

   // Count enabled edges since a word accepted on one shows after the next
   always @(posedge sys_clk) begin
      checkNow = 1'b0;
      holdNow  = 1'b0;
      if (sys_rst) begin
         acceptCount = 0;
      end else if (sys_ena) begin
         acceptCount++;
         checkNow = (acceptCount >= 2);
      end else begin
         holdNow = 1'b1;
      end
   end

   // Sample mid-cycle where wb has settled
   always @(negedge sys_clk) begin
      if (checkNow) begin
         if (expQ.size() == 0) begin
            errCount++;
            $display("A writeback appeared with no instruction outstanding at %0t", $time);
         end else begin
            compareWb(nameQ.pop_front(), expQ.pop_front(), wb);
         end
      end
      if (holdNow) begin
         compareWb("stall hold", wbLast, wb);
      end
      wbLast = wb;
   end

   // Amounts 0, 1, 31 and random with random upper rb bits
   task automatic shiftTest();
      int k;
      int n;
      logic [4:0]         amt;
      logic [DATA_W-1:0]  a;
      logic [DATA_W-1:0]  b;
      testName = "shift";
      for (k = 0; k < 3; k++) begin
         for (n = 0; n < 7; n++) begin
            case (n)
               0:       amt = 5'd0;
               1:       amt = 5'd1;
               2:       amt = 5'd31;
               default: amt = 5'($random(seed));
            endcase
            a = $random(seed);
            // Odd steps force a negative operand
            if (n[0]) begin
               a[31] = 1'b1;
            end
            b      = $random(seed);
            b[4:0] = amt;
            issue(1'b1, mkRegOp(OPC_BS, 5'(n + 1), 2'(k)), a, b);
         end
      end
   endtask

   task automatic immTest();
      int k;
      int n;
      logic [5:0]  ops [4];
      logic [15:0] imm;
      testName = "immediate";
      ops[0] = OPC_ORI;
      ops[1] = OPC_ANDI;
      ops[2] = OPC_XORI;
      ops[3] = OPC_ANDNI;
      // Kind in imm bits 10:9 with random filler elsewhere
      for (k = 0; k < 3; k++) begin
         for (n = 0; n < 4; n++) begin
            imm = {5'($random(seed)), 2'(k), 4'($random(seed)), 5'($random(seed))};
            issue(1'b1, mkImmOp(OPC_BSI, 5'(k * 4 + n), imm), $random(seed), $random(seed));
         end
      end
      // One negative and one positive immediate per op
      for (k = 0; k < 4; k++) begin
         imm = 16'($random(seed)) | 16'h8000;
         issue(1'b1, mkImmOp(ops[k], 5'(20 + k), imm), $random(seed), $random(seed));
         imm = 16'($random(seed)) & 16'h7FFF;
         issue(1'b1, mkImmOp(ops[k], 5'(24 + k), imm), $random(seed), $random(seed));
      end
   endtask

   task automatic logicTest();
      int k;
      int n;
      logic [5:0] ops [4];
      testName = "logic";
      ops[0] = OPC_OR;
      ops[1] = OPC_AND;
      ops[2] = OPC_XOR;
      ops[3] = OPC_ANDN;
      for (k = 0; k < 4; k++) begin
         for (n = 0; n < 4; n++) begin
            issue(1'b1, mkRegOp(ops[k], 5'($random(seed)), 2'b00), $random(seed), $random(seed));
         end
      end
   endtask

   // Shift and logic interleaved every cycle with or without random stalls
   task automatic mixedTest(input string name, input logic stall);
      int n;
      logic [5:0] opc;
      testName  = name;
      stallMode = stall;
      for (n = 0; n < 16; n++) begin
         if (!n[0]) begin
            opc = OPC_BS;
         end else begin
            case ($unsigned($random(seed)) % 4)
               0:       opc = OPC_OR;
               1:       opc = OPC_AND;
               2:       opc = OPC_XOR;
               default: opc = OPC_ANDN;
            endcase
         end
         issue(1'b1, mkRegOp(opc, 5'(n), 2'($unsigned($random(seed)) % 3)),
               $random(seed), $random(seed));
      end
      stallMode = 1'b0;
   endtask

   task automatic bubbleTest();
      testName = "bubble and illegal";
      issue(1'b0, mkRegOp(OPC_OR, 5'd7, 2'b00), $random(seed), $random(seed));
      // Unknown opcode without instrValid is just a bubble
      issue(1'b0, mkRegOp(6'h3F, 5'd8, 2'b00), $random(seed), $random(seed));
      issue(1'b1, mkRegOp(6'h3F, 5'd9, 2'b00), $random(seed), $random(seed));
      issue(1'b1, mkRegOp(6'h00, 5'd10, 2'b00), $random(seed), $random(seed));
      // Reserved kind in both forms
      issue(1'b1, mkRegOp(OPC_BS, 5'd11, 2'b11), $random(seed), $random(seed));
      issue(1'b1, mkImmOp(OPC_BSI, 5'd12, 16'h0605), $random(seed), $random(seed));
   endtask

   initial begin
      #(NUM_VEC * 40 + MARGIN_NS);
      $display("Watchdog expired before the tests finished");
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      sys_clk     = 1'b0;
      sys_rst     = 1'b1;
      sys_ena     = 1'b0;
      instrValid  = 1'b0;
      instr       = '0;
      rfA         = '0;
      rfB         = '0;
      seed        = 32'hdd9aecc6;
      errCount    = 0;
      checkCount  = 0;
      acceptCount = 0;
      checkNow    = 1'b0;
      holdNow     = 1'b0;
      stallMode   = 1'b0;
      wbLast      = '0;
      testName    = "reset";
      repeat (3) @(posedge sys_clk);
      #1;
      sys_rst = 1'b0;
      compareWb("reset", '0, wb);
      shiftTest();
      immTest();
      logicTest();
      mixedTest("back-to-back", 1'b0);
      mixedTest("stall", 1'b1);
      bubbleTest();
      // Two bubbles flush the last real word and then the first bubble
      testName = "drain";
      issue(1'b0, '0, '0, '0);
      issue(1'b0, '0, '0, '0);
      // Let the checker sample the first bubble
      @(negedge sys_clk);
      #1;
      // Only the second bubble is still in flight
      if (expQ.size() != 1) begin
         errCount++;
         $display("Writeback results missing, %0d words never came out", expQ.size() - 1);
      end
      $display("Checks: %0d, errors: %0d", checkCount, errCount);
      if (errCount == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verification/mbExe_props.sv */
// Bound assertions on the execute slice writeback port, attached to the top level by bind
`timescale 1ns/1ps
`default_nettype none

module mbExe_props (
   input wire logic            sys_clk,
   input wire logic            sys_rst,
   input wire logic            sys_ena,
   input wire mbExePkg::mbWbS  wb
);

   // No valid writeback in the cycle after reset
   resetClearsValid: assert property (@(posedge sys_clk) sys_rst |=> !wb.valid)
      else $error("wb.valid set in the cycle after reset");

   // Disabled edge leaves the record untouched
   stallHoldsWb: assert property (@(posedge sys_clk) disable iff (sys_rst)
      !sys_ena |=> $stable(wb))
      else $error("wb changed across an edge with sys_ena low");

   // Either valid or illegal, never both
   flagsExclusive: assert property (@(posedge sys_clk) !(wb.valid && wb.illegal))
      else $error("wb.valid and wb.illegal set together");

endmodule

`default_nettype wire

/* src/mbExeTop.sv */
// Execute slice top level: decoder, barrel shifter, logic unit and writeback selector
`timescale 1ns/1ps
`default_nettype none

module mbExeTop (
   input  wire logic                          sys_clk,
   input  wire logic                          sys_rst,
   input  wire logic                          sys_ena,
   input  wire logic                          instrValid,
   input  wire mbIsaPkg::mbInstrU             instr,
   input  wire logic [mbExePkg::DATA_W-1:0]   rfA,
   input  wire logic [mbExePkg::DATA_W-1:0]   rfB,
   output mbExePkg::mbWbS                     wb
);

   import mbExePkg::*;

   // Decoded control, valid in the cycle the instruction is presented
   mbExeCtrlS          ctrl;
   // Unit results, two enabled edges behind ctrl
   logic [DATA_W-1:0]  shiftResult;
   logic [DATA_W-1:0]  logicResult;

   // Combinational decode and operand B select
   mbOpDecode mbOpDecode_i (
      .instrValid (instrValid),
      .instr      (instr),
      .rfA        (rfA),
      .rfB        (rfB),
      .ctrl       (ctrl)
   );

   // Two-stage shifter, kind select delayed by one stage
   mbBarrelShift mbBarrelShift_i (
      .sys_clk (sys_clk),
      .sys_rst (sys_rst),
      .sys_ena (sys_ena),
      .opA     (ctrl.opA),
      .opB     (ctrl.opB),
      .kind    (ctrl.kind),
      .result  (shiftResult)
   );

   // Logic unit padded to the same latency
   mbLogicUnit mbLogicUnit_i (
      .sys_clk (sys_clk),
      .sys_rst (sys_rst),
      .sys_ena (sys_ena),
      .opA     (ctrl.opA),
      .opB     (ctrl.opB),
      .op      (ctrl.logicOp),
      .result  (logicResult)
   );

   // Tag pipeline and result mux
   mbWriteback mbWriteback_i (
      .sys_clk     (sys_clk),
      .sys_rst     (sys_rst),
      .sys_ena     (sys_ena),
      .ctrl        (ctrl),
      .shiftResult (shiftResult),
      .logicResult (logicResult),
      .wb          (wb)
   );

endmodule

`default_nettype wire

/* src/mbWriteback.sv */
// Writeback selector: delays the instruction tags two stages and muxes the unit result
`timescale 1ns/1ps
`default_nettype none

module mbWriteback (
   input  wire logic                          sys_clk,
   input  wire logic                          sys_rst,
   input  wire logic                          sys_ena,
   input  wire mbExePkg::mbExeCtrlS           ctrl,
   input  wire logic [mbExePkg::DATA_W-1:0]   shiftResult,
   input  wire logic [mbExePkg::DATA_W-1:0]   logicResult,
   output mbExePkg::mbWbS                     wb
);

   import mbExePkg::*;

   // Per-instruction tags that ride alongside the datapath
   typedef struct packed {
      logic              valid;
      logic              illegal;
      mbUnitE            unit;
      logic [REG_W-1:0]  rd;
   } wbTagS;

   // Tags at stage one and stage two
   wbTagS  tag1Q;
   wbTagS  tag2Q;

   // Two enabled stages, same depth as the units
   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         tag1Q <= '0;
         tag2Q <= '0;
      end else if (sys_ena) begin
         tag1Q.valid   <= ctrl.valid;
         tag1Q.illegal <= ctrl.illegal;
         tag1Q.unit    <= ctrl.unit;
         tag1Q.rd      <= ctrl.rd;
         tag2Q         <= tag1Q;
      end
   end

   // Result mux after the tag registers
   always_comb begin
      wb.valid   = tag2Q.valid;
      wb.illegal = tag2Q.illegal;
      wb.rd      = tag2Q.rd;
      // Bubbles and illegal words carry zero data
      wb.data    = '0;
      if (tag2Q.valid) begin
         wb.data = (tag2Q.unit == UNIT_SHIFT) ? shiftResult : logicResult;
      end
   end

endmodule

`default_nettype wire

/* src/mbLogicUnit.sv */
// Logic unit for OR, AND, XOR and AND-NOT, two stages deep to match the shifter
`timescale 1ns/1ps
`default_nettype none

module mbLogicUnit (
   input  wire logic                          sys_clk,
   input  wire logic                          sys_rst,
   input  wire logic                          sys_ena,
   input  wire logic [mbExePkg::DATA_W-1:0]   opA,
   input  wire logic [mbExePkg::DATA_W-1:0]   opB,
   input  wire mbExePkg::mbLogicOpE           op,
   output logic [mbExePkg::DATA_W-1:0]        result
);

   import mbExePkg::*;

   // Combinational result of the selected op
   logic [DATA_W-1:0]  logicNext;
   // First stage, holds the computed value
   logic [DATA_W-1:0]  logicQ;
   // Second stage, latency padding only
   logic [DATA_W-1:0]  alignQ;

   always_comb begin
      case (op)
         LOP_OR:   logicNext = opA | opB;
         LOP_AND:  logicNext = opA & opB;
         LOP_XOR:  logicNext = opA ^ opB;
         // A and not B
         LOP_ANDN: logicNext = opA & ~opB;
         default:  logicNext = '0;
      endcase
   end

   // Stage one
   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         logicQ <= '0;
      end else if (sys_ena) begin
         logicQ <= logicNext;
      end
   end

   // Stage two
   // Same enable as the shifter so both stall together
   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         alignQ <= '0;
      end else if (sys_ena) begin
         alignQ <= logicQ;
      end
   end

   assign result = alignQ;

endmodule

`default_nettype wire

/* bsft/mbBarrelShift.sv */
// Two-cycle barrel shifter: all three shifts in stage one, kind select in stage two
`timescale 1ns/1ps
`default_nettype none

module mbBarrelShift (
   input  wire logic                          sys_clk,
   input  wire logic                          sys_rst,
   input  wire logic                          sys_ena,
   input  wire logic [mbExePkg::DATA_W-1:0]   opA,
   input  wire logic [mbExePkg::DATA_W-1:0]   opB,
   input  wire mbIsaPkg::mbShiftKindE         kind,
   output logic [mbExePkg::DATA_W-1:0]        result
);

   import mbIsaPkg::*;
   import mbExePkg::*;

   // Shift amount, upper bits of operand B ignored
   logic [SHAMT_W-1:0]  shamt;

   // Stage one results
   logic [DATA_W-1:0]   sllQ;
   logic [DATA_W-1:0]   srlQ;
   logic [DATA_W-1:0]   sraQ;
   // Kind, delayed to line up with stage one
   mbShiftKindE         kindQ;

   // Stage two, selected shift
   logic [DATA_W-1:0]   selQ;

   assign shamt = opB[SHAMT_W-1:0];

   // Stage one
   // All three shifts computed in parallel, no kind decode on this path
   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         sllQ  <= '0;
         srlQ  <= '0;
         sraQ  <= '0;
         kindQ <= SK_SRL;
      end else if (sys_ena) begin
         sllQ  <= opA << shamt;
         srlQ  <= opA >> shamt;
         // Sign bit fills from the left
         sraQ  <= $signed(opA) >>> shamt;
         kindQ <= kind;
      end
   end

   // Stage two
   // Pick one by the delayed kind
   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         selQ <= '0;
      end else if (sys_ena) begin
         case (kindQ)
            SK_SRL:  selQ <= srlQ;
            SK_SRA:  selQ <= sraQ;
            SK_SLL:  selQ <= sllQ;
            // Reserved kind, decoder flags it illegal
            default: selQ <= '0;
         endcase
      end
   end

   // Straight from the stage two register
   assign result = selQ;

endmodule

`default_nettype wire

/* src/mbOpDecode.sv */
// Combinational decoder that turns an instruction word into the control record for the pipeline
`timescale 1ns/1ps
`default_nettype none

module mbOpDecode (
   input  wire logic                          instrValid,
   input  wire mbIsaPkg::mbInstrU             instr,
   input  wire logic [mbExePkg::DATA_W-1:0]   rfA,
   input  wire logic [mbExePkg::DATA_W-1:0]   rfB,
   output mbExePkg::mbExeCtrlS                ctrl
);

   import mbIsaPkg::*;
   import mbExePkg::*;

   // Opcode in the supported set
   logic               known;
   // Type B form takes operand B from the immediate
   logic               isImm;
   mbUnitE             unit;
   mbLogicOpE          logicOp;
   // Raw S and T bits
   logic [1:0]         shiftBits;
   logic               illegal;
   logic [DATA_W-1:0]  immExt;

   // Plain 16-bit sign extension since there is no IMM prefix
   assign immExt = {{(DATA_W-16){instr.typeB.imm[15]}}, instr.typeB.imm};

   // Opcode read through the type A view since both forms share its bits
   always_comb begin
      known   = 1'b1;
      isImm   = 1'b0;
      unit    = UNIT_LOGIC;
      logicOp = LOP_OR;
      case (instr.typeA.opcode)
         OPC_BS:    unit = UNIT_SHIFT;
         OPC_BSI: begin
            unit  = UNIT_SHIFT;
            isImm = 1'b1;
         end
         OPC_OR:    logicOp = LOP_OR;
         OPC_AND:   logicOp = LOP_AND;
         OPC_XOR:   logicOp = LOP_XOR;
         OPC_ANDN:  logicOp = LOP_ANDN;
         OPC_ORI: begin
            logicOp = LOP_OR;
            isImm   = 1'b1;
         end
         OPC_ANDI: begin
            logicOp = LOP_AND;
            isImm   = 1'b1;
         end
         OPC_XORI: begin
            logicOp = LOP_XOR;
            isImm   = 1'b1;
         end
         OPC_ANDNI: begin
            logicOp = LOP_ANDN;
            isImm   = 1'b1;
         end
         // Anything else is outside this slice
         default:   known = 1'b0;
      endcase
   end

   // S and T sit in word bits 10:9 in both forms
   assign shiftBits = instr.typeA.func[10:9];

   // Unknown opcode or a shift with the reserved kind
   assign illegal = instrValid &
                    (~known | ((unit == UNIT_SHIFT) & (shiftBits == 2'b11)));

   // Assemble the control record
   always_comb begin
      ctrl.valid   = instrValid & ~illegal;
      ctrl.illegal = illegal;
      ctrl.unit    = unit;
      ctrl.kind    = mbShiftKindE'(shiftBits);
      ctrl.logicOp = logicOp;
      ctrl.rd      = instr.typeA.rd;
      ctrl.opA     = rfA;
      ctrl.opB     = isImm ? immExt : rfB;
   end

endmodule

`default_nettype wire

/* common/mbExePkg.sv */
// Execute-pipeline definitions: widths, unit and op codes, control and writeback records
`default_nettype none

package mbExePkg;

   // Datapath width, fixed by the ISA
   localparam int DATA_W  = 32;
   // Register index width
   localparam int REG_W   = 5;
   // Shift amount bits taken from operand B
   localparam int SHAMT_W = 5;

   // Which unit produces the writeback data
   typedef enum logic {
      UNIT_SHIFT = 1'b0,
      UNIT_LOGIC = 1'b1
   } mbUnitE;

   // Logic unit operation
   typedef enum logic [1:0] {
      LOP_OR   = 2'd0,
      LOP_AND  = 2'd1,
      LOP_XOR  = 2'd2,
      LOP_ANDN = 2'd3
   } mbLogicOpE;

   // Decoded instruction, handed from the decoder into the pipeline
   typedef struct packed {
      logic                  valid;
      logic                  illegal;
      mbUnitE                unit;
      mbIsaPkg::mbShiftKindE kind;
      mbLogicOpE             logicOp;
      logic [REG_W-1:0]      rd;
      logic [DATA_W-1:0]     opA;
      // Register value or sign-extended immediate
      logic [DATA_W-1:0]     opB;
   } mbExeCtrlS;

   // Writeback record toward the register file
   typedef struct packed {
      logic              valid;
      logic              illegal;
      logic [REG_W-1:0]  rd;
      logic [DATA_W-1:0] data;
   } mbWbS;

endpackage

`default_nettype wire

/* common/mbIsaPkg.sv */
// Instruction-set definitions for the execute slice: opcodes, shift kinds, instruction word views
`default_nettype none

package mbIsaPkg;

   // Barrel shift, register form (type A)
   localparam logic [5:0] OPC_BS    = 6'h11;
   // Barrel shift, immediate form (type B)
   localparam logic [5:0] OPC_BSI   = 6'h19;

   // Logic ops, register form
   // Low two bits follow the logic op order OR, AND, XOR, ANDN
   localparam logic [5:0] OPC_OR    = 6'h20;
   localparam logic [5:0] OPC_AND   = 6'h21;
   localparam logic [5:0] OPC_XOR   = 6'h22;
   localparam logic [5:0] OPC_ANDN  = 6'h23;

   // Logic ops, immediate form
   // Bit 3 of the opcode marks the immediate variant
   localparam logic [5:0] OPC_ORI   = 6'h28;
   localparam logic [5:0] OPC_ANDI  = 6'h29;
   localparam logic [5:0] OPC_XORI  = 6'h2A;
   localparam logic [5:0] OPC_ANDNI = 6'h2B;

   // Shift kind, taken from word bits 10:9
   // Bit 10 is the direction S (1 = left), bit 9 is the type T (1 = arithmetic)
   // Code 3 would be an arithmetic left shift, which the ISA reserves
   typedef enum logic [1:0] {
      SK_SRL = 2'd0,
      SK_SRA = 2'd1,
      SK_SLL = 2'd2
   } mbShiftKindE;

   // Register form: rd <- ra op rb
   typedef struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [4:0]  rb;
      // Function field, S and T live in bits 10:9
      logic [10:0] func;
   } mbTypeAS;

   // Immediate form: rd <- ra op sext(imm)
   typedef struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rd;
      logic [4:0]  ra;
      // Sign extended to the data width before use
      logic [15:0] imm;
   } mbTypeBS;

   // One instruction word, two overlapping views
   // Opcode, rd and ra sit at the same bit positions in both
   typedef union packed {
      mbTypeAS typeA;
      mbTypeBS typeB;
   } mbInstrU;

endpackage

`default_nettype wire
